//--- s1c88_pkg.sv
package s1c88_pkg;

    localparam int ADDR_W = 16;
    localparam int BUS_ADDR_W = 24;
    localparam int DATA_W = 8;
    localparam logic [ADDR_W-1:0] RESET_VECTOR_ADDR = 16'h0000;

    localparam int UROM_DEPTH = 16;
    localparam int UROM_AW = $clog2(UROM_DEPTH);

    // microcode entry points, one routine per supported opcode
    localparam logic [UROM_AW-1:0] UADDR_NOP = 0;
    localparam logic [UROM_AW-1:0] UADDR_LD_A_BR = 1;
    localparam logic [UROM_AW-1:0] UADDR_LD_BR_IMM = 2;
    localparam logic [UROM_AW-1:0] UADDR_LD_MEM_IMM = 3;
    localparam logic [UROM_AW-1:0] UADDR_OR_MEM_IMM = 4;
    localparam logic [UROM_AW-1:0] UADDR_OR_MEM_WB = 5;
    localparam logic [UROM_AW-1:0] UADDR_ADD_A_IMM = 6;
    localparam logic [UROM_AW-1:0] UADDR_AND_A_IMM = 7;
    localparam logic [UROM_AW-1:0] UADDR_LD_MEM_A = 8;
    localparam logic [UROM_AW-1:0] UADDR_LD_A_ABS = 9;

    // encodings follow the external bus status pins
    typedef enum logic [1:0] {
        BUS_IDLE      = 2'd0,
        BUS_MEM_WRITE = 2'd2,
        BUS_MEM_READ  = 2'd3
    } bus_status_e;

    typedef enum logic [2:0] {
        FETCH_VEC_LOW,
        FETCH_VEC_HIGH,
        FETCH_OPCODE,
        FETCH_IMM,
        FETCH_EXECUTE
    } fetch_state_e;

    typedef enum logic [7:0] {
        OP_ADD_A_IMM  = 8'h02,
        OP_AND_A_IMM  = 8'h22,
        OP_LD_A_BR    = 8'h44,
        OP_LD_MEM_A   = 8'h78,
        OP_LD_BR_IMM  = 8'hB4,
        OP_LD_A_ABS   = 8'hB5,
        OP_OR_MEM_IMM = 8'hD9,
        OP_LD_MEM_IMM = 8'hDD
    } opcode_e;

    typedef enum logic [2:0] {ALU_NONE, ALU_AND, ALU_OR, ALU_ADD, ALU_SUB} alu_op_e;

    typedef enum logic [2:0] {
        MOV_NONE, MOV_A, MOV_BR, MOV_IMML, MOV_ALU_R, MOV_ALU_A
    } mov_sel_e;

    typedef enum logic {ADDR_BR_LL, ADDR_HHLL} addr_mode_e;

    typedef enum logic [1:0] {MICRO_MISC, MICRO_BUS_READ, MICRO_BUS_WRITE} micro_type_e;

    typedef struct packed {
        micro_type_e utype;
        addr_mode_e  amode;
        mov_sel_e    dst;
        mov_sel_e    src;
        alu_op_e     alu;
        logic        last;
    } microword_t;

endpackage

//--- s1c88_bus_if.sv
`timescale 1ns/100ps

// one requester's path into the bus unit
interface s1c88_bus_if
    import s1c88_pkg::*;
();

    logic              req_read;
    logic              req_write;
    logic [ADDR_W-1:0] req_addr;
    logic [DATA_W-1:0] req_wdata;
    // marks an opcode read
    logic              req_sync;

    logic [DATA_W-1:0] rdata;
    logic              rvalid;

    modport requester
    (
        output req_read, req_write, req_addr, req_wdata, req_sync,
        input  rdata, rvalid
    );

    modport unit
    (
        input  req_read, req_write, req_addr, req_wdata, req_sync,
        output rdata, rvalid
    );

endinterface

//--- s1c88_dispatch_if.sv
`timescale 1ns/100ps

interface s1c88_dispatch_if
    import s1c88_pkg::*;
();

    logic [DATA_W-1:0] opcode;
    // first immediate in the high half, last immediate in the low half
    logic [ADDR_W-1:0] imm;
    logic              start;

    logic [1:0]        imm_count;
    logic              done;

    modport fetch
    (
        output opcode, imm, start,
        input  imm_count, done
    );

    modport sequencer
    (
        input  opcode, start,
        output imm_count, done
    );

endinterface

//--- s1c88_fetch.sv
`timescale 1ns/100ps

module s1c88_fetch
    import s1c88_pkg::*;
(
    input logic clk,
    input logic reset,
    s1c88_bus_if.requester bus,
    s1c88_dispatch_if.fetch disp
);

    fetch_state_e      state;
    logic [ADDR_W-1:0] pc;
    logic              wait_rdata;
    logic [1:0]        imm_cnt;
    logic [DATA_W-1:0] opcode_q;
    logic [ADDR_W-1:0] imm_q;
    logic              need_imm;
    logic              fetch_read;

    assign need_imm = imm_cnt != disp.imm_count;

    // one read per byte, the next one only after rvalid
    always_comb
    begin
        fetch_read = 1'b0;
        if (!wait_rdata)
        begin
            case (state)
                FETCH_VEC_LOW, FETCH_VEC_HIGH, FETCH_OPCODE:
                    fetch_read = 1'b1;
                FETCH_IMM:
                    fetch_read = need_imm;
                default:
                    fetch_read = 1'b0;
            endcase
        end
    end

    always_comb
    begin
        case (state)
            FETCH_VEC_LOW:
                bus.req_addr = RESET_VECTOR_ADDR;
            FETCH_VEC_HIGH:
                bus.req_addr = RESET_VECTOR_ADDR + ADDR_W'(1);
            default:
                bus.req_addr = pc;
        endcase
    end

    assign bus.req_read = fetch_read;
    assign bus.req_write = 1'b0;
    assign bus.req_wdata = '0;
    assign bus.req_sync = fetch_read && (state == FETCH_OPCODE);

    assign disp.opcode = opcode_q;
    assign disp.imm = imm_q;
    assign disp.start = (state == FETCH_IMM) && !need_imm;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            state      <= FETCH_VEC_LOW;
            pc         <= '0;
            wait_rdata <= 1'b0;
            imm_cnt    <= '0;
        end
        else
        begin
            if (fetch_read)
                wait_rdata <= 1'b1;
            else if (bus.rvalid)
                wait_rdata <= 1'b0;

            case (state)
                FETCH_VEC_LOW:
                    if (bus.rvalid)
                    begin
                        pc[DATA_W-1:0] <= bus.rdata;
                        state          <= FETCH_VEC_HIGH;
                    end
                FETCH_VEC_HIGH:
                    if (bus.rvalid)
                    begin
                        pc[ADDR_W-1:DATA_W] <= bus.rdata;
                        state               <= FETCH_OPCODE;
                    end
                FETCH_OPCODE:
                    if (bus.rvalid)
                    begin
                        pc      <= pc + ADDR_W'(1);
                        imm_cnt <= '0;
                        state   <= FETCH_IMM;
                    end
                FETCH_IMM:
                    if (bus.rvalid)
                    begin
                        pc      <= pc + ADDR_W'(1);
                        imm_cnt <= imm_cnt + 2'd1;
                    end
                    else if (!need_imm)
                        state <= FETCH_EXECUTE;
                FETCH_EXECUTE:
                    if (disp.done)
                        state <= FETCH_OPCODE;
                default:
                    state <= FETCH_VEC_LOW;
            endcase
        end
    end

    // the first immediate goes into both halves, so ll always sits high and nn low
    always_ff @(posedge clk)
    begin
        if (state == FETCH_OPCODE && bus.rvalid)
            opcode_q <= bus.rdata;
        if (state == FETCH_IMM && bus.rvalid)
        begin
            if (imm_cnt == 2'd0)
                imm_q <= {bus.rdata, bus.rdata};
            else
                imm_q <= {imm_q[DATA_W-1:0], bus.rdata};
        end
    end

endmodule

//--- s1c88_microcode.sv
`timescale 1ns/100ps

module s1c88_microcode
    import s1c88_pkg::*;
(
    input logic clk,
    input logic reset,
    s1c88_dispatch_if.sequencer disp,
    output microword_t uword,
    output logic step_active,
    input logic step_done
);

    logic [UROM_AW-1:0] upc;
    logic [UROM_AW-1:0] entry_addr;
    logic               running;
    logic               step_complete;

    // translation table: opcode to routine start and immediate byte count
    always_comb
    begin
        case (opcode_e'(disp.opcode))
            OP_LD_A_BR:    begin entry_addr = UADDR_LD_A_BR;    disp.imm_count = 2'd1; end
            OP_LD_BR_IMM:  begin entry_addr = UADDR_LD_BR_IMM;  disp.imm_count = 2'd1; end
            OP_LD_MEM_IMM: begin entry_addr = UADDR_LD_MEM_IMM; disp.imm_count = 2'd2; end
            OP_OR_MEM_IMM: begin entry_addr = UADDR_OR_MEM_IMM; disp.imm_count = 2'd2; end
            OP_ADD_A_IMM:  begin entry_addr = UADDR_ADD_A_IMM;  disp.imm_count = 2'd1; end
            OP_AND_A_IMM:  begin entry_addr = UADDR_AND_A_IMM;  disp.imm_count = 2'd1; end
            OP_LD_MEM_A:   begin entry_addr = UADDR_LD_MEM_A;   disp.imm_count = 2'd1; end
            OP_LD_A_ABS:   begin entry_addr = UADDR_LD_A_ABS;   disp.imm_count = 2'd2; end
            // unknown opcodes run a single empty step
            default:       begin entry_addr = UADDR_NOP;        disp.imm_count = 2'd0; end
        endcase
    end

    // microcode ROM
    always_comb
    begin
        case (upc)
            UADDR_LD_A_BR:
                uword = '{MICRO_BUS_READ, ADDR_BR_LL, MOV_A, MOV_NONE, ALU_NONE, 1'b1};
            UADDR_LD_BR_IMM:
                uword = '{MICRO_MISC, ADDR_BR_LL, MOV_BR, MOV_IMML, ALU_NONE, 1'b1};
            UADDR_LD_MEM_IMM:
                uword = '{MICRO_BUS_WRITE, ADDR_BR_LL, MOV_NONE, MOV_IMML, ALU_NONE, 1'b1};
            // read-modify-write, the read stages the byte in ALU operand A
            UADDR_OR_MEM_IMM:
                uword = '{MICRO_BUS_READ, ADDR_BR_LL, MOV_ALU_A, MOV_NONE, ALU_NONE, 1'b0};
            UADDR_OR_MEM_WB:
                uword = '{MICRO_BUS_WRITE, ADDR_BR_LL, MOV_NONE, MOV_ALU_R, ALU_OR, 1'b1};
            UADDR_ADD_A_IMM:
                uword = '{MICRO_MISC, ADDR_BR_LL, MOV_A, MOV_ALU_R, ALU_ADD, 1'b1};
            UADDR_AND_A_IMM:
                uword = '{MICRO_MISC, ADDR_BR_LL, MOV_A, MOV_ALU_R, ALU_AND, 1'b1};
            UADDR_LD_MEM_A:
                uword = '{MICRO_BUS_WRITE, ADDR_BR_LL, MOV_NONE, MOV_A, ALU_NONE, 1'b1};
            UADDR_LD_A_ABS:
                uword = '{MICRO_BUS_READ, ADDR_HHLL, MOV_A, MOV_NONE, ALU_NONE, 1'b1};
            default:
                uword = '{MICRO_MISC, ADDR_BR_LL, MOV_NONE, MOV_NONE, ALU_NONE, 1'b1};
        endcase
    end

    assign step_active = running;
    assign step_complete = running && step_done;
    assign disp.done = step_complete && uword.last;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            running <= 1'b0;
            upc     <= UADDR_NOP;
        end
        else if (disp.start)
        begin
            running <= 1'b1;
            upc     <= entry_addr;
        end
        else if (step_complete)
        begin
            if (uword.last)
                running <= 1'b0;
            else
                upc <= upc + UROM_AW'(1);
        end
    end

endmodule

//--- s1c88_datapath.sv
`timescale 1ns/100ps

module s1c88_datapath
    import s1c88_pkg::*;
(
    input logic clk,
    input logic reset,
    input microword_t uword,
    input logic step_active,
    input logic [ADDR_W-1:0] imm,
    output logic step_done,
    s1c88_bus_if.requester bus
);

    logic [DATA_W-1:0] a_reg;
    logic [DATA_W-1:0] br;
    logic [DATA_W-1:0] alu_a;
    logic [DATA_W-1:0] alu_x;
    logic [DATA_W-1:0] alu_r;
    logic [DATA_W-1:0] src_val;
    logic [DATA_W-1:0] load_val;
    logic              load_en;
    logic              req_sent;
    logic              is_misc;
    logic              is_read;
    logic              is_write;

    assign is_misc = step_active && (uword.utype == MICRO_MISC);
    assign is_read = step_active && (uword.utype == MICRO_BUS_READ);
    assign is_write = step_active && (uword.utype == MICRO_BUS_WRITE);

    // an ALU step into A works on A itself, otherwise on the staged operand
    assign alu_x = (uword.dst == MOV_A) ? a_reg : alu_a;

    always_comb
    begin
        case (uword.alu)
            ALU_AND: alu_r = alu_x & imm[DATA_W-1:0];
            ALU_OR:  alu_r = alu_x | imm[DATA_W-1:0];
            ALU_ADD: alu_r = alu_x + imm[DATA_W-1:0];
            ALU_SUB: alu_r = alu_x - imm[DATA_W-1:0];
            default: alu_r = alu_x;
        endcase
    end

    always_comb
    begin
        case (uword.src)
            MOV_A:     src_val = a_reg;
            MOV_BR:    src_val = br;
            MOV_IMML:  src_val = imm[DATA_W-1:0];
            MOV_ALU_R: src_val = alu_r;
            MOV_ALU_A: src_val = alu_a;
            default:   src_val = '0;
        endcase
    end

    // ll is the high half of imm, hh the low half
    assign bus.req_addr = (uword.amode == ADDR_BR_LL) ?
        {br, imm[ADDR_W-1:DATA_W]} : {imm[DATA_W-1:0], imm[ADDR_W-1:DATA_W]};
    assign bus.req_read = is_read && !req_sent;
    assign bus.req_write = is_write && !req_sent;
    assign bus.req_wdata = src_val;
    assign bus.req_sync = 1'b0;

    // a bus step ends one clock after its request
    assign step_done = is_misc || (is_write && req_sent) || (is_read && req_sent && bus.rvalid);

    assign load_en = is_misc || (is_read && req_sent && bus.rvalid);
    assign load_val = is_misc ? src_val : bus.rdata;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            req_sent <= 1'b0;
            a_reg    <= '0;
            br       <= '0;
        end
        else
        begin
            if (bus.req_read || bus.req_write)
                req_sent <= 1'b1;
            else if (step_done)
                req_sent <= 1'b0;

            if (load_en && uword.dst == MOV_A)
                a_reg <= load_val;
            if (load_en && uword.dst == MOV_BR)
                br <= load_val;
        end
    end

    always_ff @(posedge clk)
    begin
        if (load_en && uword.dst == MOV_ALU_A)
            alu_a <= load_val;
    end

endmodule

//--- s1c88_bus_unit.sv
`timescale 1ns/100ps

module s1c88_bus_unit
    import s1c88_pkg::*;
(
    input logic clk,
    input logic reset,
    s1c88_bus_if.unit fetch_bus,
    s1c88_bus_if.unit exec_bus,
    input logic [DATA_W-1:0] data_in,
    output logic [DATA_W-1:0] data_out,
    output logic [BUS_ADDR_W-1:0] address_out,
    output bus_status_e bus_status,
    output logic read,
    output logic write,
    output logic sync
);

    logic fetch_req;
    logic exec_req;
    logic exec_owns;

    assign fetch_req = fetch_bus.req_read || fetch_bus.req_write;
    assign exec_req = exec_bus.req_read || exec_bus.req_write;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            read        <= 1'b0;
            write       <= 1'b0;
            sync        <= 1'b0;
            bus_status  <= BUS_IDLE;
            address_out <= '0;
            data_out    <= '0;
            exec_owns   <= 1'b0;
        end
        else if (exec_req)
        begin
            read        <= exec_bus.req_read;
            write       <= exec_bus.req_write;
            sync        <= exec_bus.req_sync;
            bus_status  <= exec_bus.req_write ? BUS_MEM_WRITE : BUS_MEM_READ;
            address_out <= {{(BUS_ADDR_W-ADDR_W){1'b0}}, exec_bus.req_addr};
            exec_owns   <= 1'b1;
            if (exec_bus.req_write)
                data_out <= exec_bus.req_wdata;
        end
        else if (fetch_req)
        begin
            read        <= fetch_bus.req_read;
            write       <= fetch_bus.req_write;
            sync        <= fetch_bus.req_sync;
            bus_status  <= fetch_bus.req_write ? BUS_MEM_WRITE : BUS_MEM_READ;
            address_out <= {{(BUS_ADDR_W-ADDR_W){1'b0}}, fetch_bus.req_addr};
            exec_owns   <= 1'b0;
            if (fetch_bus.req_write)
                data_out <= fetch_bus.req_wdata;
        end
        else
        begin
            // address and data hold between cycles
            read       <= 1'b0;
            write      <= 1'b0;
            sync       <= 1'b0;
            bus_status <= BUS_IDLE;
        end
    end

    // read data goes back only to whoever asked for it
    assign fetch_bus.rvalid = read && !exec_owns;
    assign exec_bus.rvalid = read && exec_owns;
    assign fetch_bus.rdata = exec_owns ? '0 : data_in;
    assign exec_bus.rdata = exec_owns ? data_in : '0;

endmodule

//--- s1c88_core.sv
`timescale 1ns/100ps

module s1c88_core
    import s1c88_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic [DATA_W-1:0] data_in,
    output logic [DATA_W-1:0] data_out,
    output logic [BUS_ADDR_W-1:0] address_out,
    output bus_status_e bus_status,
    output logic read,
    output logic write,
    output logic sync
);

    microword_t uword;
    logic       step_active;
    logic       step_done;

    s1c88_bus_if fetch_bus ();
    s1c88_bus_if exec_bus ();
    s1c88_dispatch_if disp ();

    s1c88_fetch u_fetch
    (
        .clk(clk),
        .reset(reset),
        .bus(fetch_bus.requester),
        .disp(disp.fetch)
    );

    s1c88_microcode u_microcode
    (
        .clk(clk),
        .reset(reset),
        .disp(disp.sequencer),
        .uword(uword),
        .step_active(step_active),
        .step_done(step_done)
    );

    // immediates reach the datapath straight from fetch
    s1c88_datapath u_datapath
    (
        .clk(clk),
        .reset(reset),
        .uword(uword),
        .step_active(step_active),
        .imm(disp.imm),
        .step_done(step_done),
        .bus(exec_bus.requester)
    );

    s1c88_bus_unit u_bus_unit
    (
        .clk(clk),
        .reset(reset),
        .fetch_bus(fetch_bus.unit),
        .exec_bus(exec_bus.unit),
        .data_in(data_in),
        .data_out(data_out),
        .address_out(address_out),
        .bus_status(bus_status),
        .read(read),
        .write(write),
        .sync(sync)
    );

endmodule

//--- s1c88_checker.sv
`timescale 1ns/100ps

module s1c88_checker
(
    input logic clk,
    input logic reset,
    input logic read,
    input logic write,
    input logic sync,
    input logic fetch_req,
    input logic exec_req
);

    // a bus cycle is either a read or a write
    read_write_excl: assert property (@(posedge clk) disable iff (reset) !(read && write))
        else $error("read and write high in the same bus cycle");

    // opcode fetches are always reads
    sync_is_read: assert property (@(posedge clk) disable iff (reset) sync |-> read)
        else $error("sync high outside a read cycle");

    // fetch stays quiet while the datapath owns the bus
    req_excl: assert property (@(posedge clk) disable iff (reset) !(fetch_req && exec_req))
        else $error("fetch and exec requests in the same cycle");

endmodule

bind s1c88_bus_unit s1c88_checker u_s1c88_checker
(
    .clk(clk),
    .reset(reset),
    .read(read),
    .write(write),
    .sync(sync),
    .fetch_req(fetch_req),
    .exec_req(exec_req)
);

//--- tb_s1c88.sv
`timescale 1ns/100ps

module tb_s1c88
    import s1c88_pkg::*;
();

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 5;
    localparam int RAND_COUNT = 40;
    localparam logic [15:0] PROG_START = 16'h0100;
    localparam logic [31:0] SEED = 32'h7879_29d6;

    logic                  clk;
    logic                  reset;
    logic [DATA_W-1:0]     data_in;
    logic [DATA_W-1:0]     data_out;
    logic [BUS_ADDR_W-1:0] address_out;
    bus_status_e           bus_status;
    logic                  read;
    logic                  write;
    logic                  sync;

    logic [7:0]  mem [0:65535];
    logic [7:0]  ref_mem [0:65535];
    logic [15:0] exp_sync [$];
    logic [15:0] exp_wr_addr [$];
    logic [7:0]  exp_wr_data [$];
    logic [15:0] prog_ptr;
    logic [15:0] end_addr;
    int          n_instr;
    bit          prog_ready;

    s1c88_core u_s1c88_core
    (
        .clk(clk),
        .reset(reset),
        .data_in(data_in),
        .data_out(data_out),
        .address_out(address_out),
        .bus_status(bus_status),
        .read(read),
        .write(write),
        .sync(sync)
    );

    // asynchronous memory, writes land on the edge that ends the cycle
    assign data_in = mem[address_out[15:0]];

    always @(posedge clk)
    begin
        if (write)
            mem[address_out[15:0]] <= data_out;
    end

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("ERROR: %s at time %0t", reason, $time);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want)
        begin
            $display("[FAIL] time %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, want);
            abort_run("bus value mismatch");
        end
    endtask

    function automatic int instr_len(input logic [7:0] op);
        case (op)
            OP_LD_MEM_IMM, OP_OR_MEM_IMM, OP_LD_A_ABS:
                return 3;
            OP_LD_A_BR, OP_LD_BR_IMM, OP_ADD_A_IMM, OP_AND_A_IMM, OP_LD_MEM_A:
                return 2;
            default:
                return 1;
        endcase
    endfunction

    task automatic put_instr(input logic [7:0] op, input logic [7:0] b1, input logic [7:0] b2);
        int len;
        len = instr_len(op);
        mem[prog_ptr] = op;
        if (len > 1)
            mem[prog_ptr + 16'd1] = b1;
        if (len > 2)
            mem[prog_ptr + 16'd2] = b2;
        prog_ptr = prog_ptr + 16'(len);
        n_instr++;
    endtask

    task automatic build_program();
        int sel;
        logic [7:0] op;
        logic [7:0] b1;
        logic [7:0] b2;
        for (int i = 0; i < 65536; i++)
            mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h3C;
        mem[0] = PROG_START[7:0];
        mem[1] = PROG_START[15:8];
        prog_ptr = PROG_START;
        n_instr = 0;
        put_instr(OP_LD_BR_IMM, 8'h80, 8'h00);
        put_instr(OP_LD_MEM_IMM, 8'h10, 8'hA5);
        // copy 0x8010 to 0x8011 through A
        put_instr(OP_LD_A_ABS, 8'h10, 8'h80);
        put_instr(OP_LD_MEM_A, 8'h11, 8'h00);
        put_instr(OP_LD_A_BR, 8'h10, 8'h00);
        // 0xA5 + 0x70 wraps to 0x15
        put_instr(OP_ADD_A_IMM, 8'h70, 8'h00);
        put_instr(OP_LD_MEM_A, 8'h12, 8'h00);
        put_instr(OP_AND_A_IMM, 8'h0F, 8'h00);
        put_instr(OP_LD_MEM_A, 8'h13, 8'h00);
        put_instr(OP_OR_MEM_IMM, 8'h10, 8'h0A);
        put_instr(8'hFF, 8'h00, 8'h00);
        put_instr(OP_LD_A_BR, 8'h10, 8'h00);
        put_instr(OP_LD_MEM_A, 8'h14, 8'h00);
        for (int k = 0; k < RAND_COUNT; k++)
        begin
            sel = int'($urandom % 8);
            b1 = 8'($urandom);
            b2 = 8'($urandom);
            case (sel)
                0: op = OP_ADD_A_IMM;
                1: op = OP_AND_A_IMM;
                2: op = OP_LD_A_BR;
                3: op = OP_LD_MEM_A;
                4: op = OP_LD_BR_IMM;
                5: op = OP_LD_A_ABS;
                6: op = OP_OR_MEM_IMM;
                default: op = OP_LD_MEM_IMM;
            endcase
            // keep BR on the upper data pages, clear of the program
            if (op == OP_LD_BR_IMM)
                b1 = {1'b1, b1[6:0]};
            put_instr(op, b1, b2);
        end
        end_addr = prog_ptr;
        mem[end_addr] = 8'hFF;
        for (int i = 0; i < 65536; i++)
            ref_mem[i] = mem[i];
    endtask

    function automatic void model_write(input logic [15:0] addr, input logic [7:0] value);
        ref_mem[addr] = value;
        exp_wr_addr.push_back(addr);
        exp_wr_data.push_back(value);
    endfunction

    // instruction-level model, one pass over the program image
    function automatic void run_model();
        logic [15:0] pc;
        logic [7:0]  a;
        logic [7:0]  br;
        logic [7:0]  op;
        logic [7:0]  b1;
        logic [7:0]  b2;
        pc = {ref_mem[16'h0001], ref_mem[16'h0000]};
        a = 8'h00;
        br = 8'h00;
        while (pc != end_addr)
        begin
            exp_sync.push_back(pc);
            op = ref_mem[pc];
            b1 = ref_mem[pc + 16'd1];
            b2 = ref_mem[pc + 16'd2];
            case (op)
                OP_LD_A_BR:    a = ref_mem[{br, b1}];
                OP_LD_BR_IMM:  br = b1;
                OP_LD_MEM_IMM: model_write({br, b1}, b2);
                OP_OR_MEM_IMM: model_write({br, b1}, ref_mem[{br, b1}] | b2);
                OP_ADD_A_IMM:  a = a + b1;
                OP_AND_A_IMM:  a = a & b1;
                OP_LD_MEM_A:   model_write({br, b1}, a);
                OP_LD_A_ABS:   a = ref_mem[{b2, b1}];
                default:       a = a;
            endcase
            pc = pc + 16'(instr_len(op));
        end
        exp_sync.push_back(end_addr);
    endfunction

    initial
    begin
        reset = 1'b1;
        prog_ready = 1'b0;
        void'($urandom(SEED));
        build_program();
        run_model();
        prog_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        check_value("read", 32'(read), 32'd0);
        check_value("write", 32'(write), 32'd0);
        check_value("sync", 32'(sync), 32'd0);
        check_value("bus_status", 32'(bus_status), 32'(BUS_IDLE));
        check_value("address_out", 32'(address_out), 32'd0);
        check_value("data_out", 32'(data_out), 32'd0);
        reset = 1'b0;
    end

    // sampled on the falling edge, away from the registered outputs
    initial
    begin : compare
        int          boot_reads;
        bit          end_seen;
        logic [15:0] want_addr;
        logic [7:0]  want_data;
        boot_reads = 0;
        end_seen = 1'b0;
        wait (prog_ready);
        while (!end_seen)
        begin
            @(negedge clk);
            if (!reset)
            begin
                if (read && boot_reads < 2)
                begin
                    check_value("address_out", 32'(address_out), 32'(boot_reads));
                    check_value("sync", 32'(sync), 32'd0);
                    boot_reads++;
                end
                if (write)
                begin
                    if (exp_wr_addr.size() == 0)
                        abort_run("a write cycle appeared that the model does not expect");
                    want_addr = exp_wr_addr.pop_front();
                    want_data = exp_wr_data.pop_front();
                    check_value("bus_status", 32'(bus_status), 32'(BUS_MEM_WRITE));
                    check_value("address_out", 32'(address_out), 32'(want_addr));
                    check_value("data_out", 32'(data_out), 32'(want_data));
                end
                if (sync)
                begin
                    if (exp_sync.size() == 0)
                        abort_run("an opcode fetch appeared past the end of the program");
                    want_addr = exp_sync.pop_front();
                    check_value("bus_status", 32'(bus_status), 32'(BUS_MEM_READ));
                    check_value("address_out", 32'(address_out), 32'(want_addr));
                    if (want_addr == end_addr)
                        end_seen = 1'b1;
                end
            end
        end
        if (exp_sync.size() != 0 || exp_wr_addr.size() != 0)
            abort_run("end address reached with expected bus cycles still missing");
        else
        begin
            $display("STATUS: PASS");
            $finish;
        end
    end

    initial
    begin : watchdog
        wait (prog_ready);
        repeat (RESET_CYCLES + 10 * n_instr) @(posedge clk);
        abort_run("timeout, the core never reached the end of the program");
    end

endmodule

//--- build.f
s1c88_pkg.sv
s1c88_bus_if.sv
s1c88_dispatch_if.sv
s1c88_fetch.sv
s1c88_microcode.sv
s1c88_datapath.sv
s1c88_bus_unit.sv
s1c88_core.sv
s1c88_checker.sv
tb_s1c88.sv

//--- run.sh
#!/bin/sh
# compile the testbench with Verilator and run it; the exit status reports pass or fail
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_s1c88

./obj_dir/Vtb_s1c88
